// File: rtl/fix_msg_pkg.sv
package fix_msg_pkg;

	// message type as classified by the receive parser
	typedef enum logic [3:0] {
		logon      = 4'd1,
		logout     = 4'd2,
		heartbeat  = 4'd3,
		resend_req = 4'd4,	// treated like app traffic here
		gap_fill   = 4'd5,
		seq_reset  = 4'd6,
		app        = 4'd7
	} msg_type_e;

	// verdict of the receive side on sequence number and checksum
	typedef enum logic [3:0] {
		valid    = 4'd0,
		garbled  = 4'd1,	// bad checksum or framing
		seq_high = 4'd2,	// gap, peer is ahead of us
		seq_low  = 4'd3,	// fatal
		invalid  = 4'd4		// fatal
	} validity_e;

endpackage

// File: rtl/fix_session_pkg.sv
package fix_session_pkg;

	// per-host session state, one word per host in the state ram
	typedef enum logic [3:0] {
		st_disconnected  = 4'd0,
		st_connected     = 4'd1,	// acceptor waiting for logon
		st_logon_sent    = 4'd2,
		st_normal        = 4'd3,
		st_hb_sent       = 4'd4,
		st_logout_sent   = 4'd5,
		st_resend_wait   = 4'd6,
		st_resend_logout = 4'd7	// logout pending behind a resend
	} session_state_e;

	// session message the creator is told to build
	typedef enum logic [1:0] {
		ord_logon      = 2'd0,
		ord_logout     = 2'd1,
		ord_heartbeat  = 2'd2,
		ord_resend_req = 2'd3
	} order_type_e;

endpackage

// File: rtl/session_state_ram.sv
`timescale 1ns/1ns

module session_state_ram #(
	parameter int HOST_BITS = 3
) (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           we_i,
	input  logic [HOST_BITS-1:0]           addr_i,
	input  fix_session_pkg::session_state_e wdata_i,
	output fix_session_pkg::session_state_e rdata_o,
	output logic                           ready_o
);
	import fix_session_pkg::*;

	session_state_e mem [2**HOST_BITS];

	logic                 clearing;	// sweep in progress
	logic [HOST_BITS-1:0] clr_addr;
	logic                 wr_en;
	logic [HOST_BITS-1:0] wr_addr;
	session_state_e       wr_data;

	// sweep takes the single write port
	assign wr_en   = clearing | we_i;
	assign wr_addr = clearing ? clr_addr : addr_i;
	assign wr_data = clearing ? st_disconnected : wdata_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			clearing <= 1'b1;
			clr_addr <= '0;
		end else if (clearing) begin
			clr_addr <= clr_addr + 1'b1;
			if (clr_addr == '1)
				clearing <= 1'b0;	// last host cleared
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	assign rdata_o = mem[addr_i];	// async read
	assign ready_o = ~clearing;

endmodule

// File: rtl/host_table.sv
`timescale 1ns/1ns

module host_table #(
	parameter int HOST_BITS = 3,
	parameter int ID_WIDTH  = 64,
	parameter int LEN_WIDTH = 4
) (
	input  logic                 clk,
	input  logic                 cfg_we_i,
	input  logic [HOST_BITS-1:0] cfg_host_i,
	input  logic [ID_WIDTH-1:0]  cfg_comp_id_i,
	input  logic [LEN_WIDTH-1:0] cfg_len_i,
	input  logic                 cfg_initiator_i,
	input  logic [HOST_BITS-1:0] rd_host_i,
	output logic [ID_WIDTH-1:0]  comp_id_o,
	output logic [LEN_WIDTH-1:0] len_o,
	output logic                 initiator_o
);

	localparam int ENTRY_W = 1 + LEN_WIDTH + ID_WIDTH;

	// entry layout, msb first: initiator flag, compid length, compid
	logic [ENTRY_W-1:0] mem [2**HOST_BITS];
	logic [ENTRY_W-1:0] rd_entry;
	logic [ENTRY_W-1:0] wr_entry;

	assign wr_entry = {cfg_initiator_i, cfg_len_i, cfg_comp_id_i};

	always_ff @(posedge clk) begin
		if (cfg_we_i)
			mem[cfg_host_i] <= wr_entry;
	end

	assign rd_entry = mem[rd_host_i];

	// unpack the entry
	assign comp_id_o   = rd_entry[ID_WIDTH-1:0];
	assign len_o       = rd_entry[ID_WIDTH +: LEN_WIDTH];
	assign initiator_o = rd_entry[ENTRY_W-1];	// 1 = we log on first

endmodule

// File: rtl/session_manager.sv
`timescale 1ns/1ns

module session_manager #(
	parameter int HOST_BITS = 3,
	parameter int ID_WIDTH  = 64,
	parameter int LEN_WIDTH = 4
) (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            msg_i,
	input  logic                            connect_i,
	input  logic                            end_session_i,
	input  logic                            timeout_i,
	input  logic                            resend_done_i,
	input  logic [HOST_BITS-1:0]            host_i,
	input  fix_msg_pkg::msg_type_e          type_i,
	input  fix_msg_pkg::validity_e          validity_i,
	input  logic                            ready_i,
	output logic                            ram_we_o,
	output logic [HOST_BITS-1:0]            ram_addr_o,
	output fix_session_pkg::session_state_e ram_wdata_o,
	input  fix_session_pkg::session_state_e ram_rdata_i,
	output logic [HOST_BITS-1:0]            ht_host_o,
	input  logic [ID_WIDTH-1:0]             comp_id_i,
	input  logic [LEN_WIDTH-1:0]            len_i,
	input  logic                            initiator_i,
	output logic                            disconnect_o,
	output logic [HOST_BITS-1:0]            disconnect_host_o,
	output logic                            ignore_o,
	output logic                            update_seq_o,
	output logic [HOST_BITS-1:0]            seq_host_o,
	output logic                            push_o,
	output fix_session_pkg::order_type_e    push_type_o,
	output logic [ID_WIDTH-1:0]             push_comp_id_o,
	output logic [LEN_WIDTH-1:0]            push_len_o
);
	import fix_msg_pkg::*;
	import fix_session_pkg::*;

	// winning event, priority connect > msg > resend_done > end_session > timeout
	logic ev_connect;
	logic ev_msg;
	logic ev_resend_done;
	logic ev_end_session;
	logic ev_timeout;

	session_state_e nxt_state;
	order_type_e    nxt_order;
	logic           do_disc;
	logic           do_ign;
	logic           do_upd;
	logic           do_push;

	assign ev_connect     = ready_i & connect_i;
	assign ev_msg         = ready_i & ~connect_i & msg_i;
	assign ev_resend_done = ready_i & ~connect_i & ~msg_i & resend_done_i;
	assign ev_end_session = ready_i & ~connect_i & ~msg_i & ~resend_done_i & end_session_i;
	assign ev_timeout     = ready_i & ~connect_i & ~msg_i & ~resend_done_i & ~end_session_i &
		timeout_i;

	// state and host table are both read for the event's host
	assign ram_addr_o = host_i;
	assign ht_host_o  = host_i;

	always_comb begin
		nxt_state = ram_rdata_i;
		nxt_order = ord_logon;
		do_disc   = 1'b0;
		do_ign    = 1'b0;
		do_upd    = 1'b0;
		do_push   = 1'b0;

		if (ev_connect) begin
			if (initiator_i) begin
				do_push   = 1'b1;
				nxt_order = ord_logon;
				nxt_state = st_logon_sent;
			end else begin
				nxt_state = st_connected;	// wait for the peer's logon
			end
		end else if (ev_msg) begin
			if (ram_rdata_i == st_disconnected) begin
				do_ign = 1'b1;
			end else if (validity_i == seq_low || validity_i == invalid) begin
				do_disc = 1'b1;
			end else begin
				case (ram_rdata_i)
				st_connected: begin
					if (type_i == logon && validity_i == valid) begin
						do_push   = 1'b1;	// answer the logon
						nxt_order = ord_logon;
						nxt_state = st_normal;
					end else begin
						do_disc = 1'b1;
					end
				end
				st_logon_sent: begin
					if (type_i == logon && validity_i == valid) begin
						nxt_state = st_normal;
					end else if (type_i == logon && validity_i == seq_high) begin
						do_push   = 1'b1;
						nxt_order = ord_resend_req;
						nxt_state = st_resend_wait;
					end else begin
						do_disc = 1'b1;
					end
				end
				st_normal, st_hb_sent: begin
					if (validity_i == garbled) begin
						do_ign = 1'b1;
					end else if (type_i == logout && validity_i == valid) begin
						do_push   = 1'b1;	// confirm the logout and drop the session
						nxt_order = ord_logout;
						nxt_state = st_disconnected;
					end else if (type_i == logout && validity_i == seq_high) begin
						do_push   = 1'b1;
						nxt_order = ord_resend_req;
						nxt_state = st_resend_logout;
					end else if (validity_i == seq_high) begin
						do_push   = 1'b1;
						nxt_order = ord_resend_req;
						nxt_state = st_resend_wait;
					end else if (type_i == heartbeat && validity_i == valid) begin
						do_push   = 1'b1;
						nxt_order = ord_heartbeat;
						nxt_state = st_hb_sent;
					end else begin
						nxt_state = st_normal;	// any traffic clears a pending heartbeat
					end
				end
				st_logout_sent: begin
					if (validity_i == garbled)
						do_ign = 1'b1;
					else
						do_disc = 1'b1;
				end
				st_resend_wait, st_resend_logout: begin
					if (validity_i == garbled) begin
						do_ign = 1'b1;
					end else if (type_i == gap_fill || type_i == seq_reset) begin
						do_upd = 1'b1;	// sequence logic reloads this host
					end else if (validity_i == seq_high) begin
						do_push   = 1'b1;
						nxt_order = ord_resend_req;
					end
				end
				default: ;
				endcase
			end
		end else if (ev_resend_done) begin
			if (ram_rdata_i == st_resend_wait) begin
				nxt_state = st_normal;
			end else if (ram_rdata_i == st_resend_logout) begin
				do_push   = 1'b1;
				nxt_order = ord_logout;
				nxt_state = st_logout_sent;
			end
		end else if (ev_end_session) begin
			if (ram_rdata_i == st_normal || ram_rdata_i == st_hb_sent) begin
				do_push   = 1'b1;
				nxt_order = ord_logout;
				nxt_state = st_logout_sent;
			end
		end else if (ev_timeout) begin
			if (ram_rdata_i == st_logon_sent || ram_rdata_i == st_logout_sent ||
			    ram_rdata_i == st_hb_sent) begin
				do_disc = 1'b1;	// peer never answered
			end else if (ram_rdata_i == st_normal) begin
				do_push   = 1'b1;
				nxt_order = ord_heartbeat;
				nxt_state = st_hb_sent;
			end
		end

		if (do_disc)
			nxt_state = st_disconnected;
	end

	// state is written on the event edge, so a follow-up event sees it
	assign ram_we_o    = (nxt_state != ram_rdata_i);
	assign ram_wdata_o = nxt_state;

	always_ff @(posedge clk) begin
		if (rst) begin
			disconnect_o <= 1'b0;
			ignore_o     <= 1'b0;
			update_seq_o <= 1'b0;
			push_o       <= 1'b0;
		end else begin
			disconnect_o <= do_disc;
			ignore_o     <= do_ign;
			update_seq_o <= do_upd;
			push_o       <= do_push;
		end
	end

	always_ff @(posedge clk) begin
		if (do_disc)
			disconnect_host_o <= host_i;
		if (do_upd)
			seq_host_o <= host_i;
		if (do_push) begin
			push_type_o    <= nxt_order;
			push_comp_id_o <= comp_id_i;	// target compid travels with the order
			push_len_o     <= len_i;
		end
	end

endmodule

// File: rtl/msg_order_queue.sv
`timescale 1ns/1ns

module msg_order_queue #(
	parameter int ID_WIDTH    = 64,
	parameter int LEN_WIDTH   = 4,
	parameter int ORDER_DEPTH = 4
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         push_i,
	input  fix_session_pkg::order_type_e push_type_i,
	input  logic [ID_WIDTH-1:0]          push_comp_id_i,
	input  logic [LEN_WIDTH-1:0]         push_len_i,
	input  logic                         create_busy_i,
	output logic                         initiate_msg_o,
	output fix_session_pkg::order_type_e order_type_o,
	output logic [ID_WIDTH-1:0]          target_comp_id_o,
	output logic [LEN_WIDTH-1:0]         comp_id_len_o,
	output logic                         overflow_o
);
	import fix_session_pkg::*;

	localparam int PTR_W = (ORDER_DEPTH > 1) ? $clog2(ORDER_DEPTH) : 1;
	localparam int CNT_W = $clog2(ORDER_DEPTH + 1);

	order_type_e          type_mem [ORDER_DEPTH];
	logic [ID_WIDTH-1:0]  id_mem   [ORDER_DEPTH];
	logic [LEN_WIDTH-1:0] len_mem  [ORDER_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;
	logic             do_wr;
	logic             do_rd;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		ptr_inc = (p == PTR_W'(ORDER_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full  = (count == CNT_W'(ORDER_DEPTH));
	assign do_wr = push_i & ~full;	// push into a full queue is lost
	// one order per initiate, never back to back, never while creator busy
	assign do_rd = (count != '0) & ~create_busy_i & ~initiate_msg_o;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr         <= '0;
			rd_ptr         <= '0;
			count          <= '0;
			initiate_msg_o <= 1'b0;
			overflow_o     <= 1'b0;
		end else begin
			initiate_msg_o <= do_rd;
			overflow_o     <= push_i & full;
			if (do_wr)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_rd)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({do_wr, do_rd})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr) begin
			type_mem[wr_ptr] <= push_type_i;
			id_mem[wr_ptr]   <= push_comp_id_i;
			len_mem[wr_ptr]  <= push_len_i;
		end
		if (do_rd) begin
			order_type_o     <= type_mem[rd_ptr];	// head goes out with the pulse
			target_comp_id_o <= id_mem[rd_ptr];
			comp_id_len_o    <= len_mem[rd_ptr];
		end
	end

endmodule

// File: rtl/fix_session_top.sv
`timescale 1ns/1ns

module fix_session_top #(
	parameter int HOST_BITS   = 3,
	parameter int ID_WIDTH    = 64,
	parameter int LEN_WIDTH   = 4,
	parameter int ORDER_DEPTH = 4
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         msg_i,
	input  fix_msg_pkg::msg_type_e       type_i,
	input  fix_msg_pkg::validity_e       validity_i,
	input  logic                         connect_i,
	input  logic                         end_session_i,
	input  logic                         timeout_i,
	input  logic                         resend_done_i,
	input  logic [HOST_BITS-1:0]         host_i,
	input  logic                         cfg_we_i,
	input  logic [HOST_BITS-1:0]         cfg_host_i,
	input  logic [ID_WIDTH-1:0]          cfg_comp_id_i,
	input  logic [LEN_WIDTH-1:0]         cfg_len_i,
	input  logic                         cfg_initiator_i,
	input  logic                         create_busy_i,
	output logic                         disconnect_o,
	output logic [HOST_BITS-1:0]         disconnect_host_o,
	output logic                         ignore_o,
	output logic                         update_seq_o,
	output logic [HOST_BITS-1:0]         seq_host_o,
	output logic                         initiate_msg_o,
	output fix_session_pkg::order_type_e order_type_o,
	output logic [ID_WIDTH-1:0]          target_comp_id_o,
	output logic [LEN_WIDTH-1:0]         comp_id_len_o,
	output logic                         overflow_o
);
	import fix_session_pkg::*;

	// state ram port
	logic                 ram_we;
	logic [HOST_BITS-1:0] ram_addr;
	session_state_e       ram_wdata;
	session_state_e       ram_rdata;
	logic                 ram_ready;

	// host table read port
	logic [HOST_BITS-1:0] ht_host;
	logic [ID_WIDTH-1:0]  ht_comp_id;
	logic [LEN_WIDTH-1:0] ht_len;
	logic                 ht_initiator;

	// manager to queue
	logic                 push;
	order_type_e          push_type;
	logic [ID_WIDTH-1:0]  push_comp_id;
	logic [LEN_WIDTH-1:0] push_len;

	session_state_ram #(.HOST_BITS(HOST_BITS)) u_state_ram (
		.clk     (clk),
		.rst     (rst),
		.we_i    (ram_we),
		.addr_i  (ram_addr),
		.wdata_i (ram_wdata),
		.rdata_o (ram_rdata),
		.ready_o (ram_ready)
	);

	host_table #(
		.HOST_BITS (HOST_BITS),
		.ID_WIDTH  (ID_WIDTH),
		.LEN_WIDTH (LEN_WIDTH)
	) u_host_table (
		.clk             (clk),
		.cfg_we_i        (cfg_we_i),
		.cfg_host_i      (cfg_host_i),
		.cfg_comp_id_i   (cfg_comp_id_i),
		.cfg_len_i       (cfg_len_i),
		.cfg_initiator_i (cfg_initiator_i),
		.rd_host_i       (ht_host),
		.comp_id_o       (ht_comp_id),
		.len_o           (ht_len),
		.initiator_o     (ht_initiator)
	);

	session_manager #(
		.HOST_BITS (HOST_BITS),
		.ID_WIDTH  (ID_WIDTH),
		.LEN_WIDTH (LEN_WIDTH)
	) u_manager (
		.clk               (clk),
		.rst               (rst),
		.msg_i             (msg_i),
		.connect_i         (connect_i),
		.end_session_i     (end_session_i),
		.timeout_i         (timeout_i),
		.resend_done_i     (resend_done_i),
		.host_i            (host_i),
		.type_i            (type_i),
		.validity_i        (validity_i),
		.ready_i           (ram_ready),
		.ram_we_o          (ram_we),
		.ram_addr_o        (ram_addr),
		.ram_wdata_o       (ram_wdata),
		.ram_rdata_i       (ram_rdata),
		.ht_host_o         (ht_host),
		.comp_id_i         (ht_comp_id),
		.len_i             (ht_len),
		.initiator_i       (ht_initiator),
		.disconnect_o      (disconnect_o),
		.disconnect_host_o (disconnect_host_o),
		.ignore_o          (ignore_o),
		.update_seq_o      (update_seq_o),
		.seq_host_o        (seq_host_o),
		.push_o            (push),
		.push_type_o       (push_type),
		.push_comp_id_o    (push_comp_id),
		.push_len_o        (push_len)
	);

	msg_order_queue #(
		.ID_WIDTH    (ID_WIDTH),
		.LEN_WIDTH   (LEN_WIDTH),
		.ORDER_DEPTH (ORDER_DEPTH)
	) u_order_queue (
		.clk              (clk),
		.rst              (rst),
		.push_i           (push),
		.push_type_i      (push_type),
		.push_comp_id_i   (push_comp_id),
		.push_len_i       (push_len),
		.create_busy_i    (create_busy_i),
		.initiate_msg_o   (initiate_msg_o),
		.order_type_o     (order_type_o),
		.target_comp_id_o (target_comp_id_o),
		.comp_id_len_o    (comp_id_len_o),
		.overflow_o       (overflow_o)
	);

endmodule

// File: verif/fix_session_properties.sv
`timescale 1ns/1ns

module fix_session_properties (
	input logic clk,
	input logic rst,
	input logic initiate_msg_i,
	input logic create_busy_i,
	input logic disconnect_i,
	input logic ignore_i,
	input logic update_seq_i,
	input logic overflow_i
);

	int unsigned assert_fails = 0;	// read by the testbench at the end

	a_no_issue_busy: assert property (@(posedge clk) disable iff (rst)
		!(initiate_msg_i && create_busy_i))
	else begin
		assert_fails++;
		$error("initiate_msg_o high while the creator is busy");
	end

	a_no_back_to_back: assert property (@(posedge clk) disable iff (rst)
		initiate_msg_i |=> !initiate_msg_i)
	else begin
		assert_fails++;
		$error("initiate_msg_o high in two consecutive cycles");
	end

	a_disc_or_ignore: assert property (@(posedge clk) disable iff (rst)
		!(disconnect_i && ignore_i))
	else begin
		assert_fails++;
		$error("disconnect_o and ignore_o high together");
	end

	// outputs settle one edge after reset is seen
	a_quiet_in_reset: assert property (@(posedge clk)
		rst |=> !(initiate_msg_i || disconnect_i || ignore_i || update_seq_i || overflow_i))
	else begin
		assert_fails++;
		$error("pulse output high during reset");
	end

endmodule

bind fix_session_top fix_session_properties u_props (
	.clk            (clk),
	.rst            (rst),
	.initiate_msg_i (initiate_msg_o),
	.create_busy_i  (create_busy_i),
	.disconnect_i   (disconnect_o),
	.ignore_i       (ignore_o),
	.update_seq_i   (update_seq_o),
	.overflow_i     (overflow_o)
);

// File: verif/fix_session_tb.sv
`timescale 1ns/1ns

module fix_session_tb;
	import fix_msg_pkg::*;
	import fix_session_pkg::*;

	localparam int HOST_BITS   = 3;
	localparam int ID_WIDTH    = 64;
	localparam int LEN_WIDTH   = 4;
	localparam int ORDER_DEPTH = 4;
	localparam int N_HOSTS     = 2**HOST_BITS;
	localparam int PERIOD      = 40;
	localparam int N_RANDOM    = 300;
	localparam int N_EVENTS    = N_RANDOM + 60;	// random plus directed, rounded up
	localparam int WATCHDOG_CYCLES = N_EVENTS * 8 + 400;

	localparam int EV_MSG         = 0;
	localparam int EV_CONNECT     = 1;
	localparam int EV_RESEND_DONE = 2;
	localparam int EV_END         = 3;
	localparam int EV_TIMEOUT     = 4;

	logic                 clk;
	logic                 rst;
	logic                 msg_stb;
	msg_type_e            msg_type;
	validity_e            validity;
	logic                 connect_stb;
	logic                 end_stb;
	logic                 timeout_stb;
	logic                 resend_done_stb;
	logic [HOST_BITS-1:0] host;
	logic                 cfg_we;
	logic [HOST_BITS-1:0] cfg_host;
	logic [ID_WIDTH-1:0]  cfg_comp_id;
	logic [LEN_WIDTH-1:0] cfg_len;
	logic                 cfg_initiator;
	logic                 create_busy;
	logic                 disconnect;
	logic [HOST_BITS-1:0] disconnect_host;
	logic                 ignore;
	logic                 update_seq;
	logic [HOST_BITS-1:0] seq_host;
	logic                 initiate_msg;
	order_type_e          order_type;
	logic [ID_WIDTH-1:0]  target_comp_id;
	logic [LEN_WIDTH-1:0] comp_id_len;
	logic                 overflow;

	// reference model
	session_state_e       model_st  [N_HOSTS];
	logic [ID_WIDTH-1:0]  host_id   [N_HOSTS];
	logic [LEN_WIDTH-1:0] host_len  [N_HOSTS];
	logic                 host_init [N_HOSTS];
	order_type_e          exp_type_q [$];
	logic [ID_WIDTH-1:0]  exp_id_q   [$];
	logic [LEN_WIDTH-1:0] exp_len_q  [$];
	logic                 exp_disc;
	logic                 exp_ign;
	logic                 exp_upd;

	int   checks        = 0;
	int   mismatches    = 0;
	int   failures      = 0;
	int   exp_overflow  = 0;
	int   overflow_seen = 0;
	int   issued        = 0;
	int   busy_left     = 0;
	logic hold_busy     = 1'b0;
	logic allow_full    = 1'b0;

	fix_session_top #(
		.HOST_BITS   (HOST_BITS),
		.ID_WIDTH    (ID_WIDTH),
		.LEN_WIDTH   (LEN_WIDTH),
		.ORDER_DEPTH (ORDER_DEPTH)
	) dut (
		.clk               (clk),
		.rst               (rst),
		.msg_i             (msg_stb),
		.type_i            (msg_type),
		.validity_i        (validity),
		.connect_i         (connect_stb),
		.end_session_i     (end_stb),
		.timeout_i         (timeout_stb),
		.resend_done_i     (resend_done_stb),
		.host_i            (host),
		.cfg_we_i          (cfg_we),
		.cfg_host_i        (cfg_host),
		.cfg_comp_id_i     (cfg_comp_id),
		.cfg_len_i         (cfg_len),
		.cfg_initiator_i   (cfg_initiator),
		.create_busy_i     (create_busy),
		.disconnect_o      (disconnect),
		.disconnect_host_o (disconnect_host),
		.ignore_o          (ignore),
		.update_seq_o      (update_seq),
		.seq_host_o        (seq_host),
		.initiate_msg_o    (initiate_msg),
		.order_type_o      (order_type),
		.target_comp_id_o  (target_comp_id),
		.comp_id_len_o     (comp_id_len),
		.overflow_o        (overflow)
	);

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	task automatic check_value(input string what, input logic [63:0] actual,
		input logic [63:0] expected);
		checks++;
		if (actual !== expected) begin
			mismatches++;
			$display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	task automatic expect_order(input order_type_e t, input int h);
		if (exp_type_q.size() >= ORDER_DEPTH) begin
			exp_overflow++;	// queue full, order lost
		end else begin
			exp_type_q.push_back(t);
			exp_id_q.push_back(host_id[h]);
			exp_len_q.push_back(host_len[h]);
		end
	endtask

	task automatic apply_rules(input int kind, input int h, input msg_type_e t,
		input validity_e v);
		session_state_e s;
		s = model_st[h];
		exp_disc = 1'b0;
		exp_ign  = 1'b0;
		exp_upd  = 1'b0;
		case (kind)
		EV_CONNECT: begin
			if (host_init[h]) begin
				expect_order(ord_logon, h);
				s = st_logon_sent;
			end else begin
				s = st_connected;
			end
		end
		EV_MSG: begin
			if (s == st_disconnected)
				exp_ign = 1'b1;
			else if (v == seq_low || v == invalid)
				exp_disc = 1'b1;
			else if (s == st_connected) begin
				if (t == logon && v == valid) begin
					expect_order(ord_logon, h);
					s = st_normal;
				end else
					exp_disc = 1'b1;
			end else if (s == st_logon_sent) begin
				if (t != logon || v == garbled)
					exp_disc = 1'b1;
				else if (v == seq_high) begin
					expect_order(ord_resend_req, h);
					s = st_resend_wait;
				end else
					s = st_normal;
			end else if (s == st_normal || s == st_hb_sent) begin
				case (v)
				garbled: exp_ign = 1'b1;
				seq_high: begin
					expect_order(ord_resend_req, h);
					s = (t == logout) ? st_resend_logout : st_resend_wait;
				end
				default: begin	// valid
					if (t == logout) begin
						expect_order(ord_logout, h);
						s = st_disconnected;
					end else if (t == heartbeat) begin
						expect_order(ord_heartbeat, h);
						s = st_hb_sent;
					end else
						s = st_normal;
				end
				endcase
			end else if (s == st_logout_sent) begin
				exp_ign  = (v == garbled);
				exp_disc = (v != garbled);
			end else begin	// both resend states, state kept
				if (v == garbled)
					exp_ign = 1'b1;
				else if (t == gap_fill || t == seq_reset)
					exp_upd = 1'b1;
				else if (v == seq_high)
					expect_order(ord_resend_req, h);
			end
		end
		EV_RESEND_DONE: begin
			if (s == st_resend_wait)
				s = st_normal;
			else if (s == st_resend_logout) begin
				expect_order(ord_logout, h);
				s = st_logout_sent;
			end
		end
		EV_END: begin
			if (s == st_normal || s == st_hb_sent) begin
				expect_order(ord_logout, h);
				s = st_logout_sent;
			end
		end
		default: begin	// timeout
			if (s == st_normal) begin
				expect_order(ord_heartbeat, h);
				s = st_hb_sent;
			end else if (s == st_logon_sent || s == st_logout_sent || s == st_hb_sent)
				exp_disc = 1'b1;
		end
		endcase
		if (exp_disc)
			s = st_disconnected;
		model_st[h] = s;
	endtask

	// called at edge + 2, returns at edge + 2
	task automatic send_event(input int kind, input int h, input msg_type_e t,
		input validity_e v, input bit extra_timeout);
		if (!allow_full) begin
			while (exp_type_q.size() >= ORDER_DEPTH) begin
				@(posedge clk);
				#2;
			end
		end
		host            = HOST_BITS'(h);
		msg_type        = t;
		validity        = v;
		msg_stb         = (kind == EV_MSG);
		connect_stb     = (kind == EV_CONNECT);
		resend_done_stb = (kind == EV_RESEND_DONE);
		end_stb         = (kind == EV_END);
		timeout_stb     = (kind == EV_TIMEOUT) || extra_timeout;	// lowest priority
		apply_rules(kind, h, t, v);
		@(posedge clk);
		#1;
		check_value("disconnect_o", disconnect, exp_disc);
		check_value("ignore_o", ignore, exp_ign);
		check_value("update_seq_o", update_seq, exp_upd);
		if (exp_disc)
			check_value("disconnect_host_o", disconnect_host, h);
		if (exp_upd)
			check_value("seq_host_o", seq_host, h);
		#1;
		msg_stb         = 1'b0;
		connect_stb     = 1'b0;
		resend_done_stb = 1'b0;
		end_stb         = 1'b0;
		timeout_stb     = 1'b0;
	endtask

	task automatic post_msg(input int h, input msg_type_e t, input validity_e v);
		send_event(EV_MSG, h, t, v, 1'b0);
	endtask

	task automatic pulse_control(input int kind, input int h);
		send_event(kind, h, app, valid, 1'b0);
	endtask

	task automatic load_host_table();
		int flip;
		flip = $urandom % 2;
		for (int h = 0; h < N_HOSTS; h++) begin
			host_id[h]    = {$urandom, $urandom};
			host_len[h]   = LEN_WIDTH'($urandom % 15 + 1);
			host_init[h]  = ((h % 2) != flip);	// half the hosts log on first
			cfg_we        = 1'b1;
			cfg_host      = HOST_BITS'(h);
			cfg_comp_id   = host_id[h];
			cfg_len       = host_len[h];
			cfg_initiator = host_init[h];
			@(posedge clk);
			#2;
		end
		cfg_we = 1'b0;
	endtask

	task automatic wait_drained();
		while (exp_type_q.size() != 0) begin
			@(posedge clk);
			#2;
		end
		repeat (5) @(posedge clk);	// longer than any busy period
		#2;
	endtask

	// creator emulation, sees initiate at edge + 1 and answers with busy
	initial begin : creator
		int n_next;
		create_busy = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			n_next = -1;
			if (overflow)
				overflow_seen++;
			if (initiate_msg) begin
				issued++;
				if (exp_type_q.size() == 0) begin
					failures++;
					$display("Error at %0t ns: order issued when none was expected", $time);
				end else begin
					check_value("order_type_o", order_type, exp_type_q.pop_front());
					check_value("target_comp_id_o", target_comp_id, exp_id_q.pop_front());
					check_value("comp_id_len_o", comp_id_len, exp_len_q.pop_front());
				end
				n_next = $urandom % 4;
			end
			#1;
			create_busy = hold_busy || (busy_left > 0);
			if (busy_left > 0)
				busy_left--;
			if (n_next >= 0)
				busy_left = n_next;	// busy starts one cycle after initiate
		end
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * PERIOD);
		$display("Error: watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
		$display("test failed");
		$finish;
	end

	initial begin : main
		int init_host;
		int acc_host;
		int init_list [$];
		int kind;
		int r;
		int issued_before;
		msg_type_e t;
		validity_e v;

		void'($urandom(48172));
		rst             = 1'b1;
		msg_stb         = 1'b0;
		msg_type        = app;
		validity        = valid;
		connect_stb     = 1'b0;
		end_stb         = 1'b0;
		timeout_stb     = 1'b0;
		resend_done_stb = 1'b0;
		host            = '0;
		cfg_we          = 1'b0;
		cfg_host        = '0;
		cfg_comp_id     = '0;
		cfg_len         = '0;
		cfg_initiator   = 1'b0;
		for (int h = 0; h < N_HOSTS; h++)
			model_st[h] = st_disconnected;

		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
		repeat (N_HOSTS + 2) @(posedge clk);	// state ram sweep
		#2;
		load_host_table();
		for (int h = 0; h < N_HOSTS; h++) begin
			if (host_init[h])
				init_list.push_back(h);
			else
				acc_host = h;
		end
		init_host = init_list[0];

		// logon from both sides
		pulse_control(EV_CONNECT, init_host);
		pulse_control(EV_CONNECT, acc_host);
		post_msg(acc_host, logon, valid);

		// timeout and end_session in several states
		pulse_control(EV_TIMEOUT, init_host);
		pulse_control(EV_END, init_host);
		pulse_control(EV_TIMEOUT, acc_host);
		pulse_control(EV_END, acc_host);
		pulse_control(EV_TIMEOUT, acc_host);
		pulse_control(EV_CONNECT, init_host);
		post_msg(init_host, logon, valid);
		pulse_control(EV_TIMEOUT, init_host);
		pulse_control(EV_TIMEOUT, init_host);

		// resend paths
		pulse_control(EV_CONNECT, init_host);
		post_msg(init_host, logon, seq_high);
		post_msg(init_host, gap_fill, valid);
		post_msg(init_host, app, garbled);
		pulse_control(EV_RESEND_DONE, init_host);
		post_msg(init_host, logout, seq_high);
		post_msg(init_host, seq_reset, seq_high);
		pulse_control(EV_END, init_host);
		pulse_control(EV_RESEND_DONE, init_host);
		post_msg(init_host, heartbeat, garbled);
		post_msg(init_host, logout, valid);

		for (int i = 0; i < N_RANDOM; i++) begin
			r    = $urandom % 8;
			kind = (r < 4) ? EV_MSG : r - 3;
			t    = ($urandom % 3 == 0) ? logon : msg_type_e'(4'($urandom % 7 + 1));
			r    = $urandom % 16;
			if (r < 9)
				v = valid;
			else if (r < 11)
				v = garbled;
			else if (r < 14)
				v = seq_high;
			else if (r == 14)
				v = seq_low;
			else
				v = invalid;
			send_event(kind, $urandom % N_HOSTS, t, v, ($urandom % 8) == 0);
		end

		// back-pressure, one push more than the queue holds
		wait_drained();
		@(posedge clk);
		#1;
		hold_busy = 1'b1;
		#1;
		@(posedge clk);
		#2;
		issued_before = issued;
		allow_full    = 1'b1;
		for (int k = 0; k < ORDER_DEPTH + 1; k++)
			pulse_control(EV_CONNECT, init_list[k % init_list.size()]);
		allow_full = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		check_value("orders issued while busy", issued - issued_before, 0);
		check_value("overflow_o pulses", overflow_seen, exp_overflow);
		@(posedge clk);
		#1;
		hold_busy = 1'b0;
		#1;
		wait_drained();

		failures += dut.u_props.assert_fails;
		$display("run complete: %0d checks, %0d mismatches, %0d other errors",
			checks, mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: compile.f
rtl/fix_msg_pkg.sv
rtl/fix_session_pkg.sv
rtl/session_state_ram.sv
rtl/host_table.sv
rtl/session_manager.sv
rtl/msg_order_queue.sv
rtl/fix_session_top.sv
verif/fix_session_properties.sv
verif/fix_session_tb.sv
